//--- include/router_consts.svh
/*
  router dimensions: port count, address width and
  header length in cycles
*/

`ifndef ROUTER_CONSTS_SVH
`define ROUTER_CONSTS_SVH

// inputs and outputs are the same count
`define ROUTER_PORTS 16

// destination address, sent LSB first
`define ROUTER_ADDR_BITS 4

// four address cycles plus one pad cycle
`define ROUTER_HDR_CYCLES 5

`endif

//--- rtl/router_port_pkg.sv
/*
  port level types: port id, per-port bit mask and the
  serial lane that one port drives toward an output
*/

`default_nettype none

`include "router_consts.svh"

package router_port_pkg;

  // names one input or output port
  typedef logic [`ROUTER_ADDR_BITS-1:0] port_id_t;

  // one bit per port, used for all top level pin vectors
  typedef logic [`ROUTER_PORTS-1:0] port_mask_t;

  // serial output of one port, active low strobes
  typedef struct packed {
    logic data;
    logic valid_n;
    logic frame_n;
  } out_lane_t;

endpackage

`default_nettype wire

//--- rtl/router_ctrl_pkg.sv
/*
  control types: input slice FSM states, slice requests
  and output ownership records
*/

`default_nettype none

package router_ctrl_pkg;

  typedef enum logic [2:0] {idle, addr, pad, request, connected} slice_state_t;

  // one slice's claim on an output
  typedef struct packed {
    logic active;
    router_port_pkg::port_id_t dest;
  } slice_req_t;

  // which input currently owns an output
  typedef struct packed {
    logic valid;
    router_port_pkg::port_id_t src;
  } owner_t;

endpackage

`default_nettype wire

//--- rtl/input_slice.sv
/*
  input slice with header parser, request holder and
  registered lane toward the output crossbar
*/

`default_nettype none

`include "router_consts.svh"

module input_slice (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        frame_n,
  input  logic                        valid_n,
  input  logic                        din,
  input  logic                        grant,
  output router_ctrl_pkg::slice_req_t req,
  output router_port_pkg::out_lane_t  lane,
  output logic                        busy_n
);

  router_ctrl_pkg::slice_state_t state;
  router_port_pkg::port_id_t     dest;
  logic [2:0]                    hdr_cnt;
  logic                          linked;

  assign linked = (state == router_ctrl_pkg::connected);

  // header FSM
  always_ff @(posedge clock) begin
    if (!reset) begin
      state   <= router_ctrl_pkg::idle;
      hdr_cnt <= '0;
    end else begin
      case (state)
        router_ctrl_pkg::idle: begin
          // frame_n falls together with address bit A0
          if (!frame_n) begin
            hdr_cnt <= 3'd1;
            state   <= router_ctrl_pkg::addr;
          end
        end
        router_ctrl_pkg::addr: begin
          hdr_cnt <= hdr_cnt + 3'd1;
          if (hdr_cnt == 3'(`ROUTER_ADDR_BITS - 1)) begin
            state <= router_ctrl_pkg::pad;
          end
        end
        router_ctrl_pkg::pad: begin
          // the single pad cycle ends the header
          state <= router_ctrl_pkg::request;
        end
        router_ctrl_pkg::request: begin
          if (grant) begin
            state <= router_ctrl_pkg::connected;
          end
        end
        router_ctrl_pkg::connected: begin
          // last payload bit comes with frame_n high
          if (frame_n) begin
            state <= router_ctrl_pkg::idle;
          end
        end
        default: state <= router_ctrl_pkg::idle;
      endcase
    end
  end

  // address arrives LSB first, so shift in from the top
  always_ff @(posedge clock) begin
    if ((state == router_ctrl_pkg::idle && !frame_n) || state == router_ctrl_pkg::addr) begin
      dest <= {din, dest[`ROUTER_ADDR_BITS-1:1]};
    end
  end

  // lane register with strobes held inactive unless connected
  always_ff @(posedge clock) begin
    if (!reset) begin
      lane.data    <= 1'b0;
      lane.valid_n <= 1'b1;
      lane.frame_n <= 1'b1;
    end else begin
      lane.data    <= din;
      lane.valid_n <= valid_n | ~linked;
      lane.frame_n <= frame_n | ~linked;
    end
  end

  always_comb begin
    req.active = (state == router_ctrl_pkg::request) || linked;
    req.dest   = dest;
  end

  // back-pressure only while waiting for the output
  assign busy_n = (state != router_ctrl_pkg::request);

endmodule

`default_nettype wire

//--- rtl/port_arbiter.sv
/*
  round-robin arbiter: one pointer and one owner register
  per output, plus the registered grant vector
*/

`default_nettype none

`include "router_consts.svh"

module port_arbiter (
  input  logic                                             clock,
  input  logic                                             reset,
  input  router_ctrl_pkg::slice_req_t [`ROUTER_PORTS-1:0] reqs,
  output router_port_pkg::port_mask_t                     grant,
  output router_ctrl_pkg::owner_t     [`ROUTER_PORTS-1:0] owners
);

  router_port_pkg::port_id_t [`ROUTER_PORTS-1:0] ptr_q;
  router_port_pkg::port_id_t [`ROUTER_PORTS-1:0] ptr_d;
  router_ctrl_pkg::owner_t   [`ROUTER_PORTS-1:0] owners_d;
  router_port_pkg::port_mask_t                   grant_d;

  always_comb begin
    logic                      found;
    router_port_pkg::port_id_t idx;

    ptr_d    = ptr_q;
    owners_d = owners;
    found    = 1'b0;
    idx      = '0;

    for (int o = 0; o < `ROUTER_PORTS; o++) begin
      if (owners[o].valid) begin
        // the source ended its frame
        if (!reqs[owners[o].src].active) begin
          owners_d[o].valid = 1'b0;
        end
      end else begin
        found = 1'b0;
        // scan from the pointer upward, wrapping at the last port
        for (int i = 0; i < `ROUTER_PORTS; i++) begin
          idx = ptr_q[o] + router_port_pkg::port_id_t'(i);
          if (!found && reqs[idx].active &&
              reqs[idx].dest == router_port_pkg::port_id_t'(o)) begin
            found             = 1'b1;
            owners_d[o].valid = 1'b1;
            owners_d[o].src   = idx;
            ptr_d[o]          = idx + 1'b1;
          end
        end
      end
    end

    // a slice asks for one dest only, so it owns at most one output
    grant_d = '0;
    for (int o = 0; o < `ROUTER_PORTS; o++) begin
      if (owners_d[o].valid) begin
        grant_d[owners_d[o].src] = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ptr_q  <= '0;
      owners <= '0;
      grant  <= '0;
    end else begin
      ptr_q  <= ptr_d;
      owners <= owners_d;
      grant  <= grant_d;
    end
  end

endmodule

`default_nettype wire

//--- rtl/output_crossbar.sv
/*
  output crossbar: selects the owning input's lane for each
  output and registers it onto the output pins
*/

`default_nettype none

`include "router_consts.svh"

module output_crossbar (
  input  logic                                             clock,
  input  logic                                             reset,
  input  router_port_pkg::out_lane_t  [`ROUTER_PORTS-1:0] lanes,
  input  router_ctrl_pkg::owner_t     [`ROUTER_PORTS-1:0] owners,
  output router_port_pkg::port_mask_t                     dout,
  output router_port_pkg::port_mask_t                     valido_n,
  output router_port_pkg::port_mask_t                     frameo_n
);

  // an unowned output shows this
  localparam router_port_pkg::out_lane_t idle_lane = '{
    data:    1'b0,
    valid_n: 1'b1,
    frame_n: 1'b1
  };

  router_port_pkg::out_lane_t [`ROUTER_PORTS-1:0] sel;

  always_comb begin
    for (int o = 0; o < `ROUTER_PORTS; o++) begin
      sel[o] = owners[o].valid ? lanes[owners[o].src] : idle_lane;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      dout     <= '0;
      valido_n <= '1;
      frameo_n <= '1;
    end else begin
      for (int o = 0; o < `ROUTER_PORTS; o++) begin
        dout[o]     <= sel[o].data;
        valido_n[o] <= sel[o].valid_n;
        frameo_n[o] <= sel[o].frame_n;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/router.sv
/*
  serial packet router top: arbiter, sixteen input slices
  and the output crossbar
*/

`default_nettype none

`include "router_consts.svh"

module router (
  input  logic                        clock,
  input  logic                        reset,
  input  router_port_pkg::port_mask_t frame_n,
  input  router_port_pkg::port_mask_t valid_n,
  input  router_port_pkg::port_mask_t din,
  output router_port_pkg::port_mask_t busy_n,
  output router_port_pkg::port_mask_t dout,
  output router_port_pkg::port_mask_t valido_n,
  output router_port_pkg::port_mask_t frameo_n
);

  router_port_pkg::port_mask_t                   grant;
  router_ctrl_pkg::slice_req_t [`ROUTER_PORTS-1:0] reqs;
  router_ctrl_pkg::owner_t     [`ROUTER_PORTS-1:0] owners;
  router_port_pkg::out_lane_t  [`ROUTER_PORTS-1:0] lanes;

  port_arbiter arbiter_inst (
    .clock  (clock),
    .reset  (reset),
    .reqs   (reqs),
    .grant  (grant),
    .owners (owners)
  );

  // one slice per input port
  for (genvar p = 0; p < `ROUTER_PORTS; p++) begin : g_slice
    input_slice slice_inst (
      .clock   (clock),
      .reset   (reset),
      .frame_n (frame_n[p]),
      .valid_n (valid_n[p]),
      .din     (din[p]),
      .grant   (grant[p]),
      .req     (reqs[p]),
      .lane    (lanes[p]),
      .busy_n  (busy_n[p])
    );
  end

  output_crossbar crossbar_inst (
    .clock    (clock),
    .reset    (reset),
    .lanes    (lanes),
    .owners   (owners),
    .dout     (dout),
    .valido_n (valido_n),
    .frameo_n (frameo_n)
  );

endmodule

`default_nettype wire

//--- tests/router_tb.sv
/*
  router testbench with clock and reset, serial packet sources, output monitors,
  queue based reference model, compare tasks and watchdog
*/

`default_nettype none

`include "router_consts.svh"

module router_tb;

  localparam int n_ports = `ROUTER_PORTS;
  localparam int max_len = 12;
  localparam int rand_pkts = 400;
  localparam int total_pkts = rand_pkts + 2 * n_ports;
  localparam int max_pkt_cycles = `ROUTER_HDR_CYCLES + 2 * max_len + 4;

  // bit i of a payload is the i-th bit sent
  typedef struct packed {
    logic [max_len-1:0] bits;
    logic [4:0]         len;
  } pkt_t;

  localparam router_port_pkg::out_lane_t idle_lane = '{
    data:    1'b0,
    valid_n: 1'b1,
    frame_n: 1'b1
  };

  logic                        clock;
  logic                        reset;
  router_port_pkg::port_mask_t frame_n;
  router_port_pkg::port_mask_t valid_n;
  router_port_pkg::port_mask_t din;
  router_port_pkg::port_mask_t busy_n;
  router_port_pkg::port_mask_t dout;
  router_port_pkg::port_mask_t valido_n;
  router_port_pkg::port_mask_t frameo_n;

  integer seed = 56231;
  int     cycle = 0;
  bit     trace_on;
  bit     match_mode;
  pkt_t   exp_q [n_ports][$];
  pkt_t   rx_q [n_ports][$];
  int     tx_cyc[$];
  int     rx_cyc[$];
  int     fall_cyc [n_ports];
  int     rise_cyc [n_ports];
  bit     in_pkt [n_ports];
  pkt_t   cur [n_ports];

  router router_inst (
    .clock    (clock),
    .reset    (reset),
    .frame_n  (frame_n),
    .valid_n  (valid_n),
    .din      (din),
    .busy_n   (busy_n),
    .dout     (dout),
    .valido_n (valido_n),
    .frameo_n (frameo_n)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  always @(posedge clock) cycle <= cycle + 1;

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_lane(input string name, input router_port_pkg::out_lane_t exp,
                            input router_port_pkg::out_lane_t act);
    if (exp !== act) begin
      stop_with_failure($sformatf("CHECK FAILED %s: expected lane %b, actual %b",
                                  name, exp, act));
    end
  endtask

  task automatic check_busy(input string name, input router_port_pkg::port_mask_t exp,
                            input router_port_pkg::port_mask_t act);
    if (exp !== act) begin
      stop_with_failure($sformatf("CHECK FAILED %s: expected busy_n %h, actual %h",
                                  name, exp, act));
    end
  endtask

  task automatic check_payload(input string name, input pkt_t exp, input pkt_t act);
    if (exp !== act) begin
      stop_with_failure($sformatf(
        "CHECK FAILED %s: expected payload %b (%0d bits), actual %b (%0d bits)",
        name, exp.bits, exp.len, act.bits, act.len));
    end
  endtask

  task automatic check_cycle(input string name, input int exp, input int act);
    if (exp != act) begin
      stop_with_failure($sformatf("CHECK FAILED %s: expected cycle %0d, actual %0d",
                                  name, exp, act));
    end
  endtask

  function automatic int rnd(input int range);
    int r;
    r = $random(seed) & 32'h7fffffff;
    return r % range;
  endfunction

  function automatic router_port_pkg::out_lane_t lane_of(input int o);
    router_port_pkg::out_lane_t l;
    l.data    = dout[o];
    l.valid_n = valido_n[o];
    l.frame_n = frameo_n[o];
    return l;
  endfunction

  // the requester at or after the round robin pointer wins
  function automatic int rr_first(input int ptr, input int a, input int b);
    if ((a - ptr + n_ports) % n_ports < (b - ptr + n_ports) % n_ports) begin
      return a;
    end
    return b;
  endfunction

  // received packet in random mode must match one expected entry
  task automatic match_packet(input int o, input pkt_t pkt);
    bit found;
    found = 1'b0;
    for (int i = 0; i < exp_q[o].size(); i++) begin
      if (!found && exp_q[o][i] == pkt) begin
        exp_q[o].delete(i);
        found = 1'b1;
      end
    end
    if (!found && exp_q[o].size() > 0) begin
      check_payload($sformatf("random traffic output %0d", o), exp_q[o][0], pkt);
    end else if (!found) begin
      stop_with_failure($sformatf("output %0d delivered a packet nobody sent to it", o));
    end
  endtask

  // collects bits with valido_n low between the fall and the rise of frameo_n
  task automatic monitor_step(input int o);
    if (!in_pkt[o] && (!frameo_n[o] || !valido_n[o])) begin
      in_pkt[o] = 1'b1;
      cur[o] = '0;
      if (!frameo_n[o]) fall_cyc[o] = cycle;
    end
    if (in_pkt[o]) begin
      if (!valido_n[o]) begin
        if (cur[o].len >= max_len) begin
          stop_with_failure($sformatf("output %0d sent a packet longer than any source", o));
        end
        cur[o].bits[cur[o].len] = dout[o];
        cur[o].len = cur[o].len + 5'd1;
        if (trace_on) rx_cyc.push_back(cycle);
      end
      if (frameo_n[o]) begin
        in_pkt[o] = 1'b0;
        rise_cyc[o] = cycle;
        if (match_mode) begin
          match_packet(o, cur[o]);
        end else begin
          rx_q[o].push_back(cur[o]);
        end
      end
    end
  endtask

  always @(negedge clock) begin
    for (int o = 0; o < n_ports; o++) begin
      if (!reset) begin
        in_pkt[o] = 1'b0;
      end else begin
        monitor_step(o);
      end
    end
  end

  // gaps[i] puts one idle cycle in front of payload bit i
  task automatic make_packet(input int min_l, input int max_l, output pkt_t pkt,
                             output logic [max_len-1:0] gaps);
    int len;
    len = min_l + rnd(max_l - min_l + 1);
    pkt = '0;
    gaps = '0;
    pkt.len = 5'(len);
    for (int i = 0; i < len; i++) begin
      pkt.bits[i] = (rnd(2) == 1);
      if (i > 0) gaps[i] = (rnd(4) == 0);
    end
  endtask

  task automatic send_packet(input int p, input router_port_pkg::port_id_t dest,
                             input pkt_t pkt, input logic [max_len-1:0] gaps);
    // address bits LSB first and then the pad cycle
    for (int i = 0; i < `ROUTER_HDR_CYCLES; i++) begin
      @(negedge clock);
      frame_n[p] = 1'b0;
      valid_n[p] = 1'b1;
      din[p] = (i < `ROUTER_ADDR_BITS) ? dest[i] : 1'b0;
    end
    // hold until the slice stops pushing back
    @(negedge clock);
    while (!busy_n[p]) @(negedge clock);
    for (int i = 0; i < pkt.len; i++) begin
      if (i > 0) @(negedge clock);
      if (i > 0 && gaps[i]) begin
        frame_n[p] = 1'b0;
        valid_n[p] = 1'b1;
        din[p] = (rnd(2) == 1);
        @(negedge clock);
      end
      frame_n[p] = (i == pkt.len - 1);
      valid_n[p] = 1'b0;
      din[p] = pkt.bits[i];
      if (trace_on) tx_cyc.push_back(cycle);
    end
    @(negedge clock);
    frame_n[p] = 1'b1;
    valid_n[p] = 1'b1;
    din[p] = 1'b0;
  endtask

  task automatic check_idle_except(input string name, input int skip);
    for (int o = 0; o < n_ports; o++) begin
      if (o != skip) check_lane($sformatf("%s output %0d", name, o), idle_lane, lane_of(o));
    end
  endtask

  task automatic directed_packet(input string name, input int src, input int dest,
                                 input pkt_t pkt, input logic [max_len-1:0] gaps);
    bit   done;
    pkt_t got;
    done = 1'b0;
    tx_cyc.delete();
    rx_cyc.delete();
    trace_on = 1'b1;
    fork
      begin
        send_packet(src, router_port_pkg::port_id_t'(dest), pkt, gaps);
        done = 1'b1;
      end
      while (!done) begin
        @(negedge clock);
        check_idle_except(name, dest);
      end
    join
    while (rx_q[dest].size() == 0) @(negedge clock);
    trace_on = 1'b0;
    got = rx_q[dest].pop_front();
    check_payload(name, pkt, got);
    check_cycle({name, " bit count"}, tx_cyc.size(), rx_cyc.size());
    // each bit leaves two edges after the source drove it
    for (int i = 0; i < tx_cyc.size(); i++) begin
      check_cycle({name, " bit timing"}, tx_cyc[i] + 2, rx_cyc[i]);
    end
    if (pkt.len > 1) check_cycle({name, " frame start"}, tx_cyc[0] + 2, fall_cyc[dest]);
    check_cycle({name, " frame end"}, tx_cyc[tx_cyc.size()-1] + 2, rise_cyc[dest]);
  endtask

  task automatic contention_round(input string name, input int winner, input int loser);
    pkt_t                        pw;
    pkt_t                        pl;
    pkt_t                        got;
    logic [max_len-1:0]          gw;
    logic [max_len-1:0]          gl;
    router_port_pkg::port_mask_t pair;
    router_port_pkg::port_mask_t exp;
    // different lengths keep the two payloads apart
    make_packet(4, 6, pw, gw);
    make_packet(8, max_len, pl, gl);
    pair = '0;
    pair[winner] = 1'b1;
    pair[loser] = 1'b1;
    exp = '0;
    exp[winner] = 1'b1;
    fork
      send_packet(winner, 4'd5, pw, gw);
      send_packet(loser, 4'd5, pl, gl);
      begin
        do @(negedge clock); while (busy_n[winner] || busy_n[loser]);
        do @(negedge clock); while (!busy_n[winner]);
        // loser waits while the winner's packet is on output 5
        while (rx_q[5].size() == 0) begin
          check_busy(name, exp, busy_n & pair);
          @(negedge clock);
        end
      end
    join
    while (rx_q[5].size() < 2) @(negedge clock);
    got = rx_q[5].pop_front();
    check_payload({name, " first"}, pw, got);
    got = rx_q[5].pop_front();
    check_payload({name, " second"}, pl, got);
  endtask

  task automatic random_source(input int p, input int count);
    pkt_t                      pkt;
    logic [max_len-1:0]        gaps;
    router_port_pkg::port_id_t dest;
    for (int k = 0; k < count; k++) begin
      dest = router_port_pkg::port_id_t'(rnd(n_ports));
      make_packet(1, max_len, pkt, gaps);
      exp_q[dest].push_back(pkt);
      send_packet(p, dest, pkt, gaps);
    end
  endtask

  initial begin
    #(total_pkts * max_pkt_cycles * 16 * 10);
    stop_with_failure("watchdog: the tests did not finish in the allowed time");
  end

  initial begin
    pkt_t               pkt;
    logic [max_len-1:0] gaps;
    int                 rr_ptr;
    int                 winner;
    int                 loser;
    int                 missing;

    reset = 1'b0;
    frame_n = '1;
    valid_n = '1;
    din = '0;
    trace_on = 1'b0;
    match_mode = 1'b0;
    repeat (4) @(negedge clock);
    reset = 1'b1;

    // idle router after reset
    repeat (20) begin
      @(negedge clock);
      check_idle_except("idle after reset", -1);
      check_busy("idle after reset", '1, busy_n);
    end

    // contention on output 5 with the pointer model at zero
    rr_ptr = 0;
    winner = rr_first(rr_ptr, 3, 9);
    loser = (winner == 3) ? 9 : 3;
    contention_round("contention round 1", winner, loser);
    make_packet(2, max_len, pkt, gaps);
    directed_packet("pointer move", 3, 5, pkt, gaps);
    rr_ptr = 4;
    winner = rr_first(rr_ptr, 3, 9);
    loser = (winner == 3) ? 9 : 3;
    contention_round("contention round 2", winner, loser);

    for (int d = 0; d < n_ports; d++) begin
      make_packet(2, max_len, pkt, gaps);
      directed_packet($sformatf("single packet to %0d", d), (d + 5) % n_ports, d, pkt, gaps);
    end

    pkt = '0;
    pkt.bits = 12'b0010_1100_1101;
    pkt.len = 5'd10;
    gaps = 12'b0000_1001_0100;
    directed_packet("valid gaps", 6, 11, pkt, gaps);

    match_mode = 1'b1;
    for (int p = 0; p < n_ports; p++) begin
      automatic int pp = p;
      fork
        random_source(pp, rand_pkts / n_ports);
      join_none
    end
    wait fork;
    repeat (8) @(negedge clock);
    missing = 0;
    for (int o = 0; o < n_ports; o++) begin
      missing = missing + exp_q[o].size();
    end

    if (missing != 0) begin
      stop_with_failure($sformatf("%0d expected packets were never delivered", missing));
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
rtl/router_port_pkg.sv
rtl/router_ctrl_pkg.sv
rtl/input_slice.sv
rtl/port_arbiter.sv
rtl/output_crossbar.sv
rtl/router.sv
tests/router_tb.sv

//--- run.sh
#!/bin/sh
# build the router testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f tb.f --top-module router_tb -o router_sim

# the testbench stops with a nonzero status on failure, the log decides
./obj_dir/router_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "router simulation reported a failure"
  exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
  echo "router simulation ended without a result"
  exit 1
fi
exit 0
